/* verilog/lwe_pkg.sv */
package lwe_pkg;

   // lwe dimensions
   localparam int n_dim    = 8;                 // vector length
   localparam int coef_w   = 16;                // coefficient width, wraps mod 2^16
   localparam int a_depth  = n_dim * n_dim;     // entries in matrix a
   localparam int a_addr_w = $clog2(a_depth);
   localparam int v_addr_w = $clog2(n_dim);

   // apb bus widths
   localparam int apb_addr_w = 12;
   localparam int apb_data_w = 32;

   // byte address map
   // each memory region is aligned to its own size,
   // so the word index is just a slice of paddr
   localparam logic [apb_addr_w-1:0] addr_ctrl   = 12'h000;
   localparam logic [apb_addr_w-1:0] addr_status = 12'h004;
   localparam logic [apb_addr_w-1:0] addr_a_base = 12'h100;  // 64 words
   localparam logic [apb_addr_w-1:0] addr_s_base = 12'h200;  // 8 words
   localparam logic [apb_addr_w-1:0] addr_e_base = 12'h240;  // 8 words
   localparam logic [apb_addr_w-1:0] addr_b_base = 12'h280;  // 8 words, read only

   // status register bits
   localparam int stat_busy = 0;
   localparam int stat_done = 1;

   // values the host writes to the control register
   typedef enum logic [1:0] {
      cmd_start = 2'd1,
      cmd_clear = 2'd2
   } cmd_t;

   // job states
   typedef enum logic [1:0] {
      st_idle,
      st_run,    // counter issuing reads
      st_drain,  // pipeline still finishing rows
      st_done
   } seq_state_t;

endpackage

/* verilog/coef_port_if.sv */
`timescale 1ns/100ps

// one port of a coefficient ram
interface coef_port_if import lwe_pkg::*; #(
   parameter int addr_w = a_addr_w
) ();

   logic [addr_w-1:0] addr;
   logic [coef_w-1:0] wdata;
   logic              we;
   logic [coef_w-1:0] rdata;  // valid one cycle after addr

   // side that issues addresses and writes
   modport host (
      output addr,
      output wdata,
      output we,
      input  rdata
   );

   // the ram itself
   modport mem (
      input  addr,
      input  wdata,
      input  we,
      output rdata
   );

endinterface

/* verilog/coef_mem.sv */
`timescale 1ns/100ps

module coef_mem import lwe_pkg::*; #(
   parameter int depth  = a_depth,
   parameter int addr_w = a_addr_w
) (
   input  logic     clk_100mhz,
   coef_port_if.mem port_a,
   coef_port_if.mem port_b
);

   logic [coef_w-1:0] ram [depth];
   logic [addr_w-1:0] addr_a;
   logic [addr_w-1:0] addr_b;

   assign addr_a = port_a.addr;
   assign addr_b = port_b.addr;

   // both ports read first, registered output
   always_ff @(posedge clk_100mhz) begin
      if (port_a.we) begin
         ram[addr_a] <= port_a.wdata;
      end
      if (port_b.we) begin
         ram[addr_b] <= port_b.wdata;
      end
      port_a.rdata <= ram[addr_a];  // old data on a same-cycle write
      port_b.rdata <= ram[addr_b];
   end

endmodule

/* verilog/apb_regs.sv */
`timescale 1ns/100ps

module apb_regs import lwe_pkg::*; (
   input  logic                  clk_100mhz,
   input  logic                  sys_rst,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [apb_addr_w-1:0] paddr,
   input  logic [apb_data_w-1:0] pwdata,
   output logic [apb_data_w-1:0] prdata,
   output logic                  pready,
   output logic                  pslverr,
   coef_port_if.host             a_host,
   coef_port_if.host             s_host,
   coef_port_if.host             e_host,
   coef_port_if.host             b_host,
   input  logic                  busy,
   input  logic                  done,
   output logic                  start_cmd,
   output logic                  clear_cmd
);

   logic acc_first;  // first access cycle, where the transfer takes effect
   logic hit_a, hit_s, hit_e, hit_b;
   logic hit_ctrl, hit_stat;
   logic mapped;
   logic is_start, is_clear;
   logic err;
   logic wr_ok;

   function automatic logic in_region(input logic [apb_addr_w-1:0] addr,
                                      input logic [apb_addr_w-1:0] base,
                                      input int                    words);
      return (addr >= base) && (addr < base + apb_addr_w'(words * 4));
   endfunction

   // address decode
   assign hit_a    = in_region(paddr, addr_a_base, a_depth);
   assign hit_s    = in_region(paddr, addr_s_base, n_dim);
   assign hit_e    = in_region(paddr, addr_e_base, n_dim);
   assign hit_b    = in_region(paddr, addr_b_base, n_dim);
   assign hit_ctrl = (paddr == addr_ctrl);
   assign hit_stat = (paddr == addr_status);
   assign mapped   = hit_a | hit_s | hit_e | hit_b | hit_ctrl | hit_stat;

   // whole word must match a command
   assign is_start = (pwdata == apb_data_w'(cmd_start));
   assign is_clear = (pwdata == apb_data_w'(cmd_clear));

   // one-bit phase counter: access cycle 1 waits, cycle 2 completes
   assign acc_first = psel & penable & ~pready;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else begin
         pready  <= acc_first;
         pslverr <= acc_first & err;  // held for the pready cycle only
      end
   end

   // error cases, a faulted transfer changes nothing
   always_comb begin
      err = 1'b0;
      if (!mapped) begin
         err = 1'b1;
      end else if (pwrite) begin
         if (hit_b || hit_stat) begin
            err = 1'b1;  // read-only locations
         end else if ((hit_a || hit_s || hit_e) && busy) begin
            err = 1'b1;  // engine owns the operands
         end else if (hit_ctrl && !(is_clear || (is_start && !busy))) begin
            err = 1'b1;  // bad command or restart while busy
         end
      end
   end

   assign wr_ok = acc_first & pwrite & ~err;

   // host ports, reads run every cycle off paddr
   assign a_host.addr  = paddr[a_addr_w+1:2];
   assign a_host.wdata = pwdata[coef_w-1:0];  // upper bits dropped
   assign a_host.we    = wr_ok & hit_a;
   assign s_host.addr  = paddr[v_addr_w+1:2];
   assign s_host.wdata = pwdata[coef_w-1:0];
   assign s_host.we    = wr_ok & hit_s;
   assign e_host.addr  = paddr[v_addr_w+1:2];
   assign e_host.wdata = pwdata[coef_w-1:0];
   assign e_host.we    = wr_ok & hit_e;
   assign b_host.addr  = paddr[v_addr_w+1:2];
   assign b_host.wdata = '0;    // results port, never written by host
   assign b_host.we    = 1'b0;

   // command pulses to the sequencer
   assign start_cmd = wr_ok & hit_ctrl & is_start;
   assign clear_cmd = wr_ok & hit_ctrl & is_clear;

   // read data, ram output settled by the second access cycle
   always_comb begin
      prdata = '0;
      if (pready && !pwrite) begin
         if (hit_a) begin
            prdata = apb_data_w'(a_host.rdata);
         end else if (hit_s) begin
            prdata = apb_data_w'(s_host.rdata);
         end else if (hit_e) begin
            prdata = apb_data_w'(e_host.rdata);
         end else if (hit_b) begin
            prdata = apb_data_w'(b_host.rdata);
         end else if (hit_stat) begin
            prdata[stat_busy] = busy;
            prdata[stat_done] = done;
         end
         // ctrl reads back as zero
      end
   end

endmodule

/* verilog/index_counter.sv */
`timescale 1ns/100ps

module index_counter import lwe_pkg::*; (
   input  logic      clk_100mhz,
   input  logic      sys_rst,
   input  logic      run_start,
   coef_port_if.host a_eng,
   coef_port_if.host s_eng,
   coef_port_if.host e_eng,
   output logic      issue_valid,
   output logic      row_last,
   output logic      job_last
);

   localparam logic [v_addr_w-1:0] last_idx = v_addr_w'(n_dim - 1);

   logic                running;
   logic [v_addr_w-1:0] row;
   logic [v_addr_w-1:0] col;

   // one step per cycle, 64 steps per job
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         running <= 1'b0;
         row     <= '0;
         col     <= '0;
      end else if (run_start) begin
         running <= 1'b1;
         row     <= '0;
         col     <= '0;
      end else if (running) begin
         if (col == last_idx) begin
            col <= '0;
            if (row == last_idx) begin
               row     <= '0;
               running <= 1'b0;  // wrapped after step 63
            end else begin
               row <= row + 1'b1;
            end
         end else begin
            col <= col + 1'b1;
         end
      end
   end

   assign issue_valid = running;
   assign row_last    = running & (col == last_idx);
   assign job_last    = row_last & (row == last_idx);

   // a[row][col] at row*n + col
   assign a_eng.addr  = a_addr_w'(row) * a_addr_w'(n_dim) + a_addr_w'(col);
   assign s_eng.addr  = col;
   assign e_eng.addr  = row;  // mac samples it on the row's last step

   // engine side only reads
   assign a_eng.wdata = '0;
   assign a_eng.we    = 1'b0;
   assign s_eng.wdata = '0;
   assign s_eng.we    = 1'b0;
   assign e_eng.wdata = '0;
   assign e_eng.we    = 1'b0;

endmodule

/* verilog/enc_sequencer.sv */
`timescale 1ns/100ps

module enc_sequencer import lwe_pkg::*; (
   input  logic clk_100mhz,
   input  logic sys_rst,
   input  logic start_cmd,
   input  logic clear_cmd,
   input  logic job_last,
   input  logic final_wr,
   output logic run_start,
   output logic busy,
   output logic done
);

   seq_state_t state;
   seq_state_t state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (start_cmd) state_nxt = st_run;
         end
         st_run: begin
            if (job_last) state_nxt = st_drain;  // last step issued
         end
         st_drain: begin
            if (final_wr) state_nxt = st_done;   // b[n-1] written
         end
         st_done: begin
            if (start_cmd) begin
               state_nxt = st_run;
            end else if (clear_cmd) begin
               state_nxt = st_idle;
            end
         end
         default: state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         state     <= st_idle;
         run_start <= 1'b0;
      end else begin
         state     <= state_nxt;
         run_start <= start_cmd;  // lines up with busy rising
      end
   end

   // status straight from state
   assign busy = (state == st_run) || (state == st_drain);
   assign done = (state == st_done);

endmodule

/* verilog/mac_unit.sv */
`timescale 1ns/100ps

module mac_unit import lwe_pkg::*; (
   input  logic      clk_100mhz,
   input  logic      sys_rst,
   input  logic      issue_valid,
   input  logic      row_last,
   input  logic      job_last,
   coef_port_if.host a_rd,
   coef_port_if.host s_rd,
   coef_port_if.host e_rd,
   coef_port_if.host b_eng,
   output logic      final_wr
);

   logic                v1, v2;       // step valid, ram out / product stage
   logic                rl1, rl2, rl3;
   logic                jl1, jl2, jl3;
   logic                acc_new;      // next product opens a row
   logic [v_addr_w-1:0] out_row;      // row being written to b
   logic [coef_w-1:0]   prod_q;
   logic [coef_w-1:0]   acc_q;
   logic [coef_w-1:0]   e_q;

   // marks follow the data through the pipe
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         v1      <= 1'b0;
         v2      <= 1'b0;
         rl1     <= 1'b0;
         rl2     <= 1'b0;
         rl3     <= 1'b0;
         jl1     <= 1'b0;
         jl2     <= 1'b0;
         jl3     <= 1'b0;
         acc_new <= 1'b1;
         out_row <= '0;
      end else begin
         v1  <= issue_valid;
         rl1 <= row_last;
         jl1 <= job_last;
         v2  <= v1;
         rl2 <= rl1;
         jl2 <= jl1;
         rl3 <= rl2;
         jl3 <= jl2;
         if (v2) acc_new <= rl2;
         if (rl3) begin
            out_row <= (out_row == v_addr_w'(n_dim - 1)) ? '0 : out_row + 1'b1;
         end
      end
   end

   // datapath, all sums wrap at coef_w
   always_ff @(posedge clk_100mhz) begin
      prod_q <= a_rd.rdata * s_rd.rdata;     // low 16 bits kept
      if (rl1) e_q <= e_rd.rdata;            // e[row] read on last column
      if (v2) acc_q <= (acc_new ? '0 : acc_q) + prod_q;
   end

   // row write, overlaps next row's first products
   assign b_eng.addr  = out_row;
   assign b_eng.wdata = acc_q + e_q;
   assign b_eng.we    = rl3;
   assign final_wr    = jl3;  // row n-1 going into b

endmodule

/* verilog/lwe_core.sv */
`timescale 1ns/100ps

module lwe_core import lwe_pkg::*; (
   input  logic                  clk_100mhz,
   input  logic                  sys_rst,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [apb_addr_w-1:0] paddr,
   input  logic [apb_data_w-1:0] pwdata,
   output logic [apb_data_w-1:0] prdata,
   output logic                  pready,
   output logic                  pslverr
);

   logic start_cmd, clear_cmd;
   logic run_start;
   logic busy, done;
   logic issue_valid, row_last, job_last;
   logic final_wr;

   // port a host side, port b engine side
   coef_port_if #(.addr_w(a_addr_w)) a_pa ();
   coef_port_if #(.addr_w(a_addr_w)) a_pb ();
   coef_port_if #(.addr_w(v_addr_w)) s_pa ();
   coef_port_if #(.addr_w(v_addr_w)) s_pb ();
   coef_port_if #(.addr_w(v_addr_w)) e_pa ();
   coef_port_if #(.addr_w(v_addr_w)) e_pb ();
   coef_port_if #(.addr_w(v_addr_w)) b_pa ();
   coef_port_if #(.addr_w(v_addr_w)) b_pb ();

   coef_mem #(.depth(a_depth), .addr_w(a_addr_w)) a_mem (
      .clk_100mhz (clk_100mhz),
      .port_a     (a_pa.mem),
      .port_b     (a_pb.mem)
   );

   coef_mem #(.depth(n_dim), .addr_w(v_addr_w)) s_mem (
      .clk_100mhz (clk_100mhz),
      .port_a     (s_pa.mem),
      .port_b     (s_pb.mem)
   );

   coef_mem #(.depth(n_dim), .addr_w(v_addr_w)) e_mem (
      .clk_100mhz (clk_100mhz),
      .port_a     (e_pa.mem),
      .port_b     (e_pb.mem)
   );

   coef_mem #(.depth(n_dim), .addr_w(v_addr_w)) b_mem (
      .clk_100mhz (clk_100mhz),
      .port_a     (b_pa.mem),  // host reads results
      .port_b     (b_pb.mem)   // mac writes results
   );

   apb_regs apb_regs_inst (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .a_host     (a_pa.host),
      .s_host     (s_pa.host),
      .e_host     (e_pa.host),
      .b_host     (b_pa.host),
      .busy       (busy),
      .done       (done),
      .start_cmd  (start_cmd),
      .clear_cmd  (clear_cmd)
   );

   enc_sequencer enc_sequencer_inst (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .start_cmd  (start_cmd),
      .clear_cmd  (clear_cmd),
      .job_last   (job_last),
      .final_wr   (final_wr),
      .run_start  (run_start),
      .busy       (busy),
      .done       (done)
   );

   // counter drives the engine addresses, mac takes the read data
   index_counter index_counter_inst (
      .clk_100mhz  (clk_100mhz),
      .sys_rst     (sys_rst),
      .run_start   (run_start),
      .a_eng       (a_pb.host),
      .s_eng       (s_pb.host),
      .e_eng       (e_pb.host),
      .issue_valid (issue_valid),
      .row_last    (row_last),
      .job_last    (job_last)
   );

   mac_unit mac_unit_inst (
      .clk_100mhz  (clk_100mhz),
      .sys_rst     (sys_rst),
      .issue_valid (issue_valid),
      .row_last    (row_last),
      .job_last    (job_last),
      .a_rd        (a_pb.host),
      .s_rd        (s_pb.host),
      .e_rd        (e_pb.host),
      .b_eng       (b_pb.host),
      .final_wr    (final_wr)
   );

endmodule

/* test/tb_lwe_core.sv */
`timescale 1ns/100ps

module tb_lwe_core;

   // register and region addresses of the core
   localparam logic [11:0] ctrl_addr   = 12'h000;
   localparam logic [11:0] status_addr = 12'h004;
   localparam logic [11:0] a_base      = 12'h100;
   localparam logic [11:0] s_base      = 12'h200;
   localparam logic [11:0] e_base      = 12'h240;
   localparam logic [11:0] b_base      = 12'h280;
   localparam int          n           = 8;  // vector length

   logic        clk_100mhz = 1'b0;
   logic        sys_rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [11:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   // reference copy of the operands
   logic [15:0] a_m [n*n];
   logic [15:0] s_m [n];
   logic [15:0] e_m [n];

   // parsed test lines
   string       t_kind [$];
   string       t_name [$];
   logic [31:0] t_arg1 [$];
   logic [31:0] t_arg2 [$];
   logic [31:0] t_arg3 [$];

   int n_checks = 0;
   int n_errors = 0;
   bit loaded   = 1'b0;  // watchdog starts once lines are counted

   always #5 clk_100mhz = ~clk_100mhz;  // 100 MHz

   lwe_core lwe_core_inst (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr)
   );

   // b[row] = sum a[row][j]*s[j] + e[row], wraps at 16 bits
   function automatic logic [15:0] expected_b(input int row);
      logic [15:0] acc;
      acc = e_m[row];
      for (int j = 0; j < n; j++) begin
         acc = acc + a_m[row*n + j] * s_m[j];
      end
      return acc;
   endfunction

   function automatic logic [15:0] model_value(input logic [11:0] addr);
      if (addr >= a_base && addr < s_base) return a_m[int'((addr - a_base) >> 2)];
      if (addr >= s_base && addr < s_base + 12'h20) return s_m[int'((addr - s_base) >> 2)];
      if (addr >= e_base && addr < e_base + 12'h20) return e_m[int'((addr - e_base) >> 2)];
      return 16'h0;
   endfunction

   // only the low 16 bits are kept by the core
   task automatic model_store(input logic [11:0] addr, input logic [31:0] data);
      if (addr >= a_base && addr < s_base) a_m[int'((addr - a_base) >> 2)] = data[15:0];
      if (addr >= s_base && addr < s_base + 12'h20) s_m[int'((addr - s_base) >> 2)] = data[15:0];
      if (addr >= e_base && addr < e_base + 12'h20) e_m[int'((addr - e_base) >> 2)] = data[15:0];
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      n_checks++;
      assert (got === exp) else begin
         $display("MISMATCH %s expected %h actual %h", name, exp, got);
         n_errors++;
      end
   endtask

   // one apb transfer, setup then access until pready
   task automatic bus_transfer(input string name, input logic wr, input logic [11:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      int wait_cycles;
      wait_cycles = 0;
      rdata = '0;
      err = 1'b0;
      @(posedge clk_100mhz);
      #1;
      psel    = 1'b1;  // setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk_100mhz);
      #1;
      penable = 1'b1;
      do begin
         @(posedge clk_100mhz);
         #1;
         wait_cycles++;
      end while (!pready && wait_cycles < 8);
      if (pready) begin
         rdata = prdata;  // stable a step after the edge
         err   = pslverr;
         check_value({name, " wait states"}, 32'd1, 32'(wait_cycles));  // exactly one
      end else begin
         $display("no pready from the DUT for %s at address %h", name, addr);
         n_errors++;
      end
      @(posedge clk_100mhz);
      #1;
      check_value({name, " pready width"}, 32'h0, {31'h0, pready});  // one cycle pulse
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic write_check(input string name, input logic [11:0] addr,
                              input logic [31:0] data, input logic exp_err);
      logic [31:0] rdata;
      logic        err;
      bus_transfer(name, 1'b1, addr, data, rdata, err);
      check_value({name, " slverr"}, {31'h0, exp_err}, {31'h0, err});
      if (!exp_err) model_store(addr, data);  // faulted writes change nothing
   endtask

   task automatic read_check(input string name, input logic [11:0] addr,
                             input logic [31:0] exp, input logic exp_err);
      logic [31:0] rdata;
      logic        err;
      bus_transfer(name, 1'b0, addr, 32'h0, rdata, err);
      check_value(name, exp, rdata);
      check_value({name, " slverr"}, {31'h0, exp_err}, {31'h0, err});
   endtask

   // mode 0 random, 1 ramp from start, 2 all ones
   task automatic fill_region(input string name, input logic [11:0] base,
                              input int mode, input logic [31:0] start);
      int          words;
      logic [31:0] data;
      words = (base == a_base) ? n*n : n;
      for (int i = 0; i < words; i++) begin
         case (mode)
            0: data = $urandom;
            1: data = start + i * 32'h111;  // carries into the dropped bits
            default: data = 32'hffff_ffff;
         endcase
         write_check(name, base + 12'(i*4), data, 1'b0);
      end
   endtask

   task automatic compare_region(input string name, input logic [11:0] base);
      int          words;
      logic [11:0] addr;
      words = (base == a_base) ? n*n : n;
      for (int i = 0; i < words; i++) begin
         addr = base + 12'(i*4);
         read_check(name, addr, {16'h0, model_value(addr)}, 1'b0);
      end
   endtask

   task automatic check_results(input string name);
      for (int i = 0; i < n; i++) begin
         read_check(name, b_base + 12'(i*4), {16'h0, expected_b(i)}, 1'b0);
      end
   endtask

   // poll status until done, bounded
   task automatic wait_done(input string name);
      logic [31:0] stat;
      logic        err;
      int          polls;
      stat  = '0;
      polls = 0;
      while (!stat[1] && polls < 200) begin
         bus_transfer(name, 1'b0, status_addr, 32'h0, stat, err);
         polls++;
      end
      if (!stat[1]) begin
         $display("job %s did not report done after %0d status reads", name, polls);
         n_errors++;
      end else begin
         check_value({name, " status"}, 32'h2, stat);  // busy low, done high
      end
   endtask

   task automatic run_test(input int i);
      string       kind;
      string       name;
      logic [11:0] base;
      int          mode;
      kind = t_kind[i];
      name = t_name[i];
      base = t_arg1[i][11:0];
      mode = (kind == "fillr") ? 0 : 2;
      if (kind == "rd") begin
         read_check(name, base, t_arg2[i], t_arg3[i][0]);
      end else if (kind == "wr") begin
         write_check(name, base, t_arg2[i], t_arg3[i][0]);
      end else if ((kind == "fillr" || kind == "fillm") && base == 12'h0) begin
         fill_region(name, a_base, mode, 0);  // base 0 means all operands
         fill_region(name, s_base, mode, 0);
         fill_region(name, e_base, mode, 0);
      end else if (kind == "fillr" || kind == "fillm") begin
         fill_region(name, base, mode, 0);
      end else if (kind == "fillp") begin
         fill_region(name, base, 1, t_arg2[i]);
      end else if (kind == "cmp") begin
         compare_region(name, a_base);
         compare_region(name, s_base);
         compare_region(name, e_base);
      end else if (kind == "wait") begin
         wait_done(name);
      end else if (kind == "bchk") begin
         check_results(name);
      end else begin
         $display("unknown test kind %s in line %s", kind, name);
         n_errors++;
      end
   endtask

   initial begin
      int          fd;
      string       line;
      string       kind;
      string       name;
      logic [31:0] a1;
      logic [31:0] a2;
      logic [31:0] a3;
      sys_rst = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      void'($urandom(32'h529b2ce7));
      fd = $fopen("test/lwe_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open test/lwe_tests.txt");
         n_errors++;
      end else begin
         while ($fgets(line, fd)) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
               if ($sscanf(line, "%s %s %h %h %h", kind, name, a1, a2, a3) == 5) begin
                  t_kind.push_back(kind);
                  t_name.push_back(name);
                  t_arg1.push_back(a1);
                  t_arg2.push_back(a2);
                  t_arg3.push_back(a3);
               end
            end
         end
         $fclose(fd);
      end
      loaded = 1'b1;
      repeat (10) @(posedge clk_100mhz);
      #1;
      sys_rst = 1'b0;
      foreach (t_kind[i]) begin
         run_test(i);
      end
      $display("checks %0d errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // run limit scales with the number of test lines
   initial begin
      int limit;
      wait (loaded);
      limit = t_kind.size() * 200 + 1000;
      repeat (limit) @(posedge clk_100mhz);
      $display("timeout after %0d cycles, checks %0d errors %0d", limit, n_checks, n_errors);
      $display("TEST FAIL");
      $finish;
   end

endmodule

/* test/lwe_tests.txt */
# columns: kind name arg1 arg2 arg3, all args in hex
# rd/wr: addr data slverr | fillr/fillm: base (0 = a, s and e) | fillp: base start | others: 0 0 0
rd    stat_after_reset  004 00000000 0
rd    unmapped_gap      00c 00000000 1
rd    unmapped_high     ffc 00000000 1
wr    a_upper_dropped   104 dead1234 0
rd    a_readback        104 00001234 0
wr    s_upper_dropped   21c ffff8001 0
rd    s_readback        21c 00008001 0
wr    e_upper_dropped   240 0001beef 0
rd    e_readback        240 0000beef 0
fillr random_fill       000 00000000 0
cmp   random_readback   000 00000000 0
wr    start_job1        000 00000001 0
rd    busy_job1         004 00000001 0
wr    a_write_busy      100 00001111 1
wr    s_write_busy      204 00002222 1
wr    e_write_busy      248 00003333 1
wr    restart_busy      000 00000001 1
wr    b_write_busy      280 00004444 1
wait  job1_done         000 00000000 0
bchk  job1_results      000 00000000 0
cmp   operands_kept     000 00000000 0
wr    b_write_idle      284 00000005 1
wr    status_write      004 00000000 1
wr    cmd_illegal       000 00000003 1
wr    cmd_zero          000 00000000 1
bchk  job1_unchanged    000 00000000 0
wr    clear_done        000 00000002 0
rd    stat_cleared      004 00000000 0
fillm a_max             100 00000000 0
fillm s_max             200 00000000 0
fillp e_ramp            240 0000fff0 0
wr    start_job2        000 00000001 0
wait  job2_done         000 00000000 0
bchk  job2_results      000 00000000 0
fillr reload_random     000 00000000 0
wr    start_job3        000 00000001 0
wait  job3_done         000 00000000 0
bchk  job3_results      000 00000000 0

/* lwe_core.f */
verilog/lwe_pkg.sv
verilog/coef_port_if.sv
verilog/coef_mem.sv
verilog/apb_regs.sv
verilog/index_counter.sv
verilog/enc_sequencer.sv
verilog/mac_unit.sv
verilog/lwe_core.sv
test/tb_lwe_core.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_lwe_core \
   -f lwe_core.f -o sim_lwe_core &&
   ./obj_dir/sim_lwe_core | tee /dev/stderr | grep -q "^TEST PASS$" ||
   exit 1
